// ==== design/dcache_ctrl.sv ====
// One request at a time; processor must hold cpu_adr and cpu_we steady until cpu_ack
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
  input  wire               cs,
  input  wire               reset,
  // Processor port
  input  wire               cpu_cyc,
  input  wire               cpu_stb,
  input  wire               cpu_we,
  input  dcache_pkg::addr_t cpu_adr,
  output logic              cpu_ack,
  // Tag store
  input  wire               hit,
  output logic              lookup,
  output logic              tag_fill,
  // Line store
  output logic              line_fill,
  output logic              word_merge,
  input  dcache_pkg::line_t line,
  // Memory port
  output logic              mem_cyc,
  output logic              mem_stb,
  output logic              mem_we,
  output dcache_pkg::addr_t mem_adr,
  output dcache_pkg::line_t mem_dat_w,
  input  wire               mem_ack
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    MERGE,
    WRITE_THROUGH,
    RESPOND
  } state_t;

  state_t state;
  state_t state_next;
  logic   req;

  // New request seen while idle
  assign req = cpu_cyc && cpu_stb;

  always_ff @(posedge cs) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req) begin
          state_next = LOOKUP;
        end
      end
      LOOKUP: begin
        // Hit result is registered, valid in this state
        if (!hit) begin
          state_next = REFILL;
        end else if (cpu_we) begin
          state_next = MERGE;
        end else begin
          state_next = RESPOND;
        end
      end
      REFILL: begin
        if (mem_ack) begin
          state_next = cpu_we ? MERGE : RESPOND;  // Write-allocate
        end
      end
      MERGE: begin
        state_next = WRITE_THROUGH;
      end
      WRITE_THROUGH: begin
        if (mem_ack) begin
          state_next = RESPOND;
        end
      end
      RESPOND: begin
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // Strobes to the stores
  always_comb begin
    lookup     = (state == IDLE) && req;
    tag_fill   = (state == REFILL) && mem_ack;
    line_fill  = (state == REFILL) && mem_ack;
    word_merge = (state == MERGE);
  end

  // Processor answer, one cycle
  assign cpu_ack = (state == RESPOND);

  // Memory cycle held for as long as the state waits on mem_ack
  always_comb begin
    mem_cyc = (state == REFILL) || (state == WRITE_THROUGH);
    mem_stb = mem_cyc;
    mem_we  = (state == WRITE_THROUGH);
  end

  // Line aligned address
  assign mem_adr = {cpu_adr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_BITS],
                    {dcache_pkg::OFFSET_BITS{1'b0}}};

  // Merged line straight from the store, stable during write-through
  assign mem_dat_w = line;

endmodule

`default_nettype wire

// ==== design/dcache_line_store.sv ====
// Line data has no reset; contents are only trusted once the tag store marks the set valid
`timescale 1ns/1ps
`default_nettype none

module dcache_line_store #(
  parameter int SET_BITS = 3
) (
  input  wire                 cs,
  input  wire                 reset,
  input  dcache_pkg::addr_t   cpu_adr,
  input  wire                 line_fill,
  input  wire                 word_merge,
  input  dcache_pkg::line_t   mem_dat_r,
  input  dcache_pkg::word_t   cpu_dat_w,
  input  dcache_pkg::sel_t    cpu_sel,
  output dcache_pkg::word_t   rd_word,
  output dcache_pkg::line_t   line
);

  localparam int SETS = 2 ** SET_BITS;
  localparam int WORD_W = dcache_pkg::WORD_W;

  typedef logic [SET_BITS-1:0] set_idx_t;

  dcache_pkg::line_t     lines [SETS];
  set_idx_t              set_idx;
  dcache_pkg::word_idx_t word_idx;

  always_comb begin
    set_idx  = cpu_adr[dcache_pkg::INDEX_LSB +: SET_BITS];
    word_idx = cpu_adr[dcache_pkg::WORD_LSB +: dcache_pkg::WORD_SEL_BITS];
  end

  // Refill takes the whole line, merge only the enabled bytes
  always_ff @(posedge cs) begin
    if (!reset) begin  // No writes while held in reset
      if (line_fill) begin
        lines[set_idx] <= mem_dat_r;
      end else if (word_merge) begin
        for (int b = 0; b < dcache_pkg::BYTES_PER_WORD; b++) begin
          if (cpu_sel[b]) begin
            lines[set_idx][word_idx*WORD_W + b*8 +: 8] <= cpu_dat_w[b*8 +: 8];
          end
        end
      end
    end
  end

  // Whole line for write-through
  assign line = lines[set_idx];

  // Selected word for the read answer
  assign rd_word = line[word_idx*WORD_W +: WORD_W];

endmodule

`default_nettype wire

// ==== design/dcache_pkg.sv ====
// Fixed 32-bit byte addresses and 256-bit lines of eight words; index width is set per module
`default_nettype none

package dcache_pkg;

  // Processor side widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int BYTES_PER_WORD = WORD_W / 8;

  // Line geometry
  localparam int LINE_WORDS = 8;
  localparam int LINE_W = LINE_WORDS * WORD_W;  // 256 bits
  localparam int OFFSET_BITS = 5;               // Byte offset within a line

  // Address field positions
  localparam int BYTE_BITS = 2;                 // Byte within a word
  localparam int WORD_LSB = BYTE_BITS;          // Word select starts here
  localparam int WORD_SEL_BITS = OFFSET_BITS - BYTE_BITS;
  localparam int INDEX_LSB = OFFSET_BITS;       // Set index starts here

  // Byte address
  typedef logic [ADDR_W-1:0] addr_t;

  // One processor word
  typedef logic [WORD_W-1:0] word_t;

  // Word 0 sits in the low bits
  typedef logic [LINE_W-1:0] line_t;

  // Byte enables of one word
  typedef logic [BYTES_PER_WORD-1:0] sel_t;

  // Word position inside a line
  typedef logic [WORD_SEL_BITS-1:0] word_idx_t;

endpackage

`default_nettype wire

// ==== design/dcache_tag_store.sv ====
// Direct mapped; hit is registered and only meaningful in the cycle after a lookup strobe
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store #(
  parameter int SET_BITS = 3
) (
  input  wire               cs,
  input  wire               reset,
  input  dcache_pkg::addr_t cpu_adr,
  input  wire               lookup,
  input  wire               tag_fill,
  output logic              hit
);

  localparam int SETS = 2 ** SET_BITS;
  localparam int TAG_W = dcache_pkg::ADDR_W - SET_BITS - dcache_pkg::OFFSET_BITS;
  localparam int TAG_LSB = dcache_pkg::INDEX_LSB + SET_BITS;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [SET_BITS-1:0] set_idx_t;

  tag_t     tags  [SETS];  // Tag RAM, no reset
  logic     valid [SETS];
  set_idx_t set_idx;
  tag_t     tag;

  // Address split
  always_comb begin
    set_idx = cpu_adr[dcache_pkg::INDEX_LSB +: SET_BITS];
    tag     = cpu_adr[TAG_LSB +: TAG_W];
  end

  // Valid bits, cleared on reset
  always_ff @(posedge cs) begin
    if (reset) begin
      for (int i = 0; i < SETS; i++) begin
        valid[i] <= 1'b0;
      end
    end else if (tag_fill) begin
      valid[set_idx] <= 1'b1;
    end
  end

  always_ff @(posedge cs) begin
    if (tag_fill) begin
      tags[set_idx] <= tag;
    end
  end

  // Lookup stage, result held until next strobe
  always_ff @(posedge cs) begin
    if (reset) begin
      hit <= 1'b0;
    end else if (lookup) begin
      hit <= valid[set_idx] && (tags[set_idx] == tag);
    end
  end

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
// Write-through, write-allocate, no burst cycles; SET_BITS sets the number of lines
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter int SET_BITS = 3
) (
  input  wire               cs,
  input  wire               reset,
  // Processor port, Wishbone slave
  input  wire               cpu_cyc,
  input  wire               cpu_stb,
  input  wire               cpu_we,
  input  dcache_pkg::addr_t cpu_adr,
  input  dcache_pkg::sel_t  cpu_sel,
  input  dcache_pkg::word_t cpu_dat_w,
  output logic              cpu_ack,
  output dcache_pkg::word_t cpu_dat_r,
  // Memory port, Wishbone master
  output logic              mem_cyc,
  output logic              mem_stb,
  output logic              mem_we,
  output dcache_pkg::addr_t mem_adr,
  output dcache_pkg::line_t mem_dat_w,
  input  wire               mem_ack,
  input  dcache_pkg::line_t mem_dat_r
);

  logic              hit;
  logic              lookup;
  logic              tag_fill;
  logic              line_fill;
  logic              word_merge;
  dcache_pkg::line_t line;

  dcache_tag_store #(
    .SET_BITS (SET_BITS)
  ) i_tag_store (
    .cs       (cs),
    .reset    (reset),
    .cpu_adr  (cpu_adr),
    .lookup   (lookup),
    .tag_fill (tag_fill),
    .hit      (hit)
  );

  dcache_line_store #(
    .SET_BITS (SET_BITS)
  ) i_line_store (
    .cs         (cs),
    .reset      (reset),
    .cpu_adr    (cpu_adr),
    .line_fill  (line_fill),
    .word_merge (word_merge),
    .mem_dat_r  (mem_dat_r),
    .cpu_dat_w  (cpu_dat_w),
    .cpu_sel    (cpu_sel),
    .rd_word    (cpu_dat_r),  // Read data straight from the array
    .line       (line)
  );

  dcache_ctrl i_ctrl (
    .cs         (cs),
    .reset      (reset),
    .cpu_cyc    (cpu_cyc),
    .cpu_stb    (cpu_stb),
    .cpu_we     (cpu_we),
    .cpu_adr    (cpu_adr),
    .cpu_ack    (cpu_ack),
    .hit        (hit),
    .lookup     (lookup),
    .tag_fill   (tag_fill),
    .line_fill  (line_fill),
    .word_merge (word_merge),
    .line       (line),
    .mem_cyc    (mem_cyc),
    .mem_stb    (mem_stb),
    .mem_we     (mem_we),
    .mem_adr    (mem_adr),
    .mem_dat_w  (mem_dat_w),
    .mem_ack    (mem_ack)
  );

endmodule

`default_nettype wire

// ==== dv/dcache_sva.sv ====
// Bound to dcache_top; assumes reset is held for at least one clock at the start
`timescale 1ns/1ps
`default_nettype none

module dcache_sva (
  input wire               cs,
  input wire               reset,
  input wire               cpu_cyc,
  input wire               cpu_stb,
  input wire               cpu_we,
  input dcache_pkg::addr_t cpu_adr,
  input dcache_pkg::sel_t  cpu_sel,
  input dcache_pkg::word_t cpu_dat_w,
  input wire               cpu_ack,
  input wire               mem_cyc,
  input wire               mem_stb,
  input wire               mem_we,
  input dcache_pkg::addr_t mem_adr,
  input dcache_pkg::line_t mem_dat_w,
  input wire               mem_ack
);

  // Processor request held until ack
  cpu_hold: assert property (@(posedge cs) disable iff (reset)
    cpu_cyc && cpu_stb && !cpu_ack |=> cpu_cyc && cpu_stb && $stable(cpu_we)
      && $stable(cpu_adr) && $stable(cpu_sel) && $stable(cpu_dat_w))
    else $error("processor request changed before cpu_ack");

  mem_hold: assert property (@(posedge cs) disable iff (reset)
    mem_cyc && mem_stb && !mem_ack |=> mem_cyc && mem_stb && $stable(mem_we)
      && $stable(mem_adr) && $stable(mem_dat_w))
    else $error("memory request changed before mem_ack");

  cpu_ack_pulse: assert property (@(posedge cs) disable iff (reset) cpu_ack |=> !cpu_ack)
    else $error("cpu_ack high for more than one cycle");

  stb_in_cyc: assert property (@(posedge cs) disable iff (reset) mem_stb |-> mem_cyc)
    else $error("mem_stb high without mem_cyc");

  // Outputs quiet once reset has been seen
  reset_state: assert property (@(posedge cs)
    reset |=> !cpu_ack && !mem_cyc && !mem_stb && !mem_we)
    else $error("port outputs not low after reset");

endmodule

bind dcache_top dcache_sva i_dcache_sva (.*);

`default_nettype wire

// ==== dv/tb_dcache.sv ====
// Expects SET_BITS of 3; the memory model covers only the first 2 KiB, so all stimulus stays there
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

  localparam int SET_BITS = 3;
  localparam int SETS = 2 ** SET_BITS;
  localparam int LINE_BYTES = dcache_pkg::LINE_W / 8;
  localparam int MEM_LINE_BITS = 6;
  localparam int MEM_LINES = 2 ** MEM_LINE_BITS;  // 2 KiB modeled
  localparam int MEM_BYTES = MEM_LINES * LINE_BYTES;
  localparam int RANDOM_OPS = 200;
  localparam int NUM_REQUESTS = 10 + RANDOM_OPS;
  localparam int CYCLE_LIMIT = NUM_REQUESTS * 400;

  logic                  cs;
  logic                  reset;
  logic                  cpu_cyc;
  logic                  cpu_stb;
  logic                  cpu_we;
  dcache_pkg::addr_t     cpu_adr;
  dcache_pkg::sel_t      cpu_sel;
  dcache_pkg::word_t     cpu_dat_w;
  logic                  cpu_ack;
  dcache_pkg::word_t     cpu_dat_r;
  logic                  mem_cyc;
  logic                  mem_stb;
  logic                  mem_we;
  dcache_pkg::addr_t     mem_adr;
  dcache_pkg::line_t     mem_dat_w;
  logic                  mem_ack;
  dcache_pkg::line_t     mem_dat_r;

  dcache_pkg::line_t     mem_lines [MEM_LINES];  // Line memory model
  logic [7:0]            ref_bytes [MEM_BYTES];  // Shadow byte memory
  logic                  ref_valid [SETS];
  dcache_pkg::addr_t     ref_tag   [SETS];
  int                    mem_reads = 0;
  int                    mem_writes = 0;
  int                    op_log [$];             // 0 read, 1 write
  dcache_pkg::addr_t     last_mem_adr;
  int                    last_latency;
  logic [31:0]           lat_state = 32'd22587;
  logic [31:0]           stim_state = 32'd22587;

  dcache_top #(
    .SET_BITS (SET_BITS)
  ) i_dcache_top (
    .cs        (cs),
    .reset     (reset),
    .cpu_cyc   (cpu_cyc),
    .cpu_stb   (cpu_stb),
    .cpu_we    (cpu_we),
    .cpu_adr   (cpu_adr),
    .cpu_sel   (cpu_sel),
    .cpu_dat_w (cpu_dat_w),
    .cpu_ack   (cpu_ack),
    .cpu_dat_r (cpu_dat_r),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .mem_ack   (mem_ack),
    .mem_dat_r (mem_dat_r)
  );

  initial begin
    cs = 1'b0;
    forever #4 cs = ~cs;
  end

  function automatic logic [31:0] lcg_step(inout logic [31:0] st);
    st = st * 32'd1103515245 + 32'd12345;
    return st;
  endfunction

  // Odd multiplier, so every address bit shows in the pattern
  function automatic dcache_pkg::word_t fill_word(input dcache_pkg::addr_t a);
    return (a * 32'h9E3779B1) ^ 32'hC3A5_5A3C;
  endfunction

  // Expected read word; updates shadow tags and bytes, reports expected traffic
  function automatic dcache_pkg::word_t ref_access(input logic we, input dcache_pkg::addr_t adr,
      input dcache_pkg::sel_t sel, input dcache_pkg::word_t wdat, output int exp_rd,
      output int exp_wr);
    int                set;
    dcache_pkg::addr_t tag;
    dcache_pkg::addr_t base;
    dcache_pkg::word_t rd;
    set = int'((adr >> dcache_pkg::OFFSET_BITS) % SETS);
    tag = adr >> (dcache_pkg::OFFSET_BITS + SET_BITS);
    exp_rd = (ref_valid[set] && ref_tag[set] == tag) ? 0 : 1;
    ref_valid[set] = 1'b1;  // Miss allocates, reads and writes alike
    ref_tag[set] = tag;
    base = {adr[31:2], 2'b00};
    exp_wr = we ? 1 : 0;
    for (int b = 0; b < 4; b++) begin
      if (we && sel[b]) begin
        ref_bytes[base + b] = wdat[b*8 +: 8];
      end
      rd[b*8 +: 8] = ref_bytes[base + b];
    end
    return rd;
  endfunction

  function automatic dcache_pkg::line_t ref_line(input int l);
    dcache_pkg::line_t ln;
    for (int b = 0; b < LINE_BYTES; b++) begin
      ln[b*8 +: 8] = ref_bytes[l*LINE_BYTES + b];
    end
    return ln;
  endfunction

  task automatic stop_on_error();
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_word(input string name, input dcache_pkg::word_t exp,
      input dcache_pkg::word_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string name, input dcache_pkg::addr_t exp,
      input dcache_pkg::addr_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_line(input string name, input dcache_pkg::line_t exp,
      input dcache_pkg::line_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      stop_on_error();
    end
  endtask

  // Memory slave, ack after 1 to 4 cycles
  initial begin : mem_model
    int delay;
    int idx;
    mem_ack = 1'b0;
    mem_dat_r = '0;
    forever begin
      @(posedge cs);
      if (!reset && mem_cyc && mem_stb) begin
        delay = int'((lcg_step(lat_state) >> 16) % 4) + 1;
        idx = int'(mem_adr[dcache_pkg::OFFSET_BITS +: MEM_LINE_BITS]);
        repeat (delay - 1) @(posedge cs);
        #1;
        mem_ack = 1'b1;
        mem_dat_r = mem_lines[idx];
        @(posedge cs);  // DUT takes the ack here
        if (mem_we) begin
          mem_lines[idx] = mem_dat_w;
          mem_writes++;
          op_log.push_back(1);
        end else begin
          mem_reads++;
          op_log.push_back(0);
        end
        last_mem_adr = mem_adr;
        #1 mem_ack = 1'b0;
      end
    end
  end

  // Latency counts edges from stb seen to ack seen
  task automatic cpu_access(input logic we, input dcache_pkg::addr_t adr,
      input dcache_pkg::sel_t sel, input dcache_pkg::word_t wdat,
      output dcache_pkg::word_t rdata, output int latency);
    int edges;
    edges = 0;
    cpu_cyc = 1'b1;
    cpu_stb = 1'b1;
    cpu_we = we;
    cpu_adr = adr;
    cpu_sel = sel;
    cpu_dat_w = wdat;
    do begin
      @(posedge cs);
      edges++;
    end while (!cpu_ack);
    rdata = cpu_dat_r;
    latency = edges - 1;
    #1;
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we = 1'b0;
  endtask

  task automatic do_request(input string name, input logic we, input dcache_pkg::addr_t adr,
      input dcache_pkg::sel_t sel, input dcache_pkg::word_t wdat);
    int                exp_rd;
    int                exp_wr;
    int                rd0;
    int                wr0;
    dcache_pkg::word_t exp_word;
    dcache_pkg::word_t got;
    exp_word = ref_access(we, adr, sel, wdat, exp_rd, exp_wr);
    rd0 = mem_reads;
    wr0 = mem_writes;
    cpu_access(we, adr, sel, wdat, got, last_latency);
    if (!we) begin
      check_word(name, exp_word, got);
    end
    check_count({name, " mem reads"}, exp_rd, mem_reads - rd0);
    check_count({name, " mem writes"}, exp_wr, mem_writes - wr0);
  endtask

  task automatic check_memory_image();
    for (int l = 0; l < MEM_LINES; l++) begin
      check_line($sformatf("memory image line %0d", l), ref_line(l), mem_lines[l]);
    end
  endtask

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge cs);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("SIMULATION FAILED");
    $fatal(1, "Timeout");
  end

  initial begin : stimulus
    logic [31:0]       rnd;
    dcache_pkg::word_t w;
    int                n0;
    reset = 1'b1;
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we = 1'b0;
    cpu_adr = '0;
    cpu_sel = '0;
    cpu_dat_w = '0;
    for (int a = 0; a < MEM_BYTES; a += 4) begin
      w = fill_word(a);
      mem_lines[a / LINE_BYTES][(a % LINE_BYTES)*8 +: 32] = w;
      for (int b = 0; b < 4; b++) begin
        ref_bytes[a + b] = w[b*8 +: 8];
      end
    end
    for (int s = 0; s < SETS; s++) begin
      ref_valid[s] = 1'b0;
    end
    repeat (8) @(posedge cs);
    #1 reset = 1'b0;

    do_request("read miss after reset", 1'b0, 32'h044, 4'hf, '0);
    check_addr("refill address", 32'h040, last_mem_adr);
    do_request("read hit other word", 1'b0, 32'h05c, 4'hf, '0);
    check_count("read hit latency", 2, last_latency);
    do_request("read hit same word", 1'b0, 32'h044, 4'hf, '0);
    check_count("read hit latency again", 2, last_latency);

    rnd = lcg_step(stim_state);
    do_request("write hit", 1'b1, 32'h048, rnd[27:24], lcg_step(stim_state));
    check_line("write hit line", ref_line(2), mem_lines[2]);
    do_request("read after write hit", 1'b0, 32'h048, 4'hf, '0);

    n0 = op_log.size();
    do_request("write miss", 1'b1, 32'h1a4, 4'b0110, 32'hdead_beef);
    check_count("write miss memory cycles", 2, op_log.size() - n0);
    check_count("write miss first cycle is read", 0, op_log[n0]);
    check_count("write miss second cycle is write", 1, op_log[n0 + 1]);
    check_line("write miss line", ref_line(13), mem_lines[13]);

    // Same set 6, tags 0 and 2
    for (int k = 0; k < 4; k++) begin
      do_request($sformatf("eviction read %0d", k), 1'b0, k[0] ? 32'h2c0 : 32'h0c0, 4'hf, '0);
    end

    for (int i = 0; i < RANDOM_OPS; i++) begin
      rnd = lcg_step(stim_state);
      do_request($sformatf("random op %0d", i), rnd[31], {22'd0, rnd[23:16], 2'b00},
                 rnd[27:24], lcg_step(stim_state));
    end
    check_memory_image();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
design/dcache_pkg.sv
design/dcache_tag_store.sv
design/dcache_line_store.sv
design/dcache_ctrl.sv
design/dcache_top.sv
dv/dcache_sva.sv
dv/tb_dcache.sv
